// File: design/axi_pkg.sv
package axi_pkg;

  // default bus widths
  parameter int ADDR_W_DEFAULT = 32;
  parameter int DATA_W_DEFAULT = 64;

  // response codes on b and r channels
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: design/mem_pkg.sv
package mem_pkg;

  // default depth in 64-bit words
  parameter int MEM_WORDS_DEFAULT = 1024;

  // byte offset inside a 64-bit word
  localparam int WORD_OFFSET_BITS = 3;

endpackage

// File: design/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 64
) ();

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // write address
  logic                  aw_valid;
  logic                  aw_ready;
  logic [ADDR_WIDTH-1:0] aw_addr;

  // write data
  logic                  w_valid;
  logic                  w_ready;
  logic [DATA_WIDTH-1:0] w_data;
  logic [STRB_WIDTH-1:0] w_strb;

  // write response
  logic                  b_valid;
  logic                  b_ready;
  logic [1:0]            b_resp;

  // read address
  logic                  ar_valid;
  logic                  ar_ready;
  logic [ADDR_WIDTH-1:0] ar_addr;

  // read data
  logic                  r_valid;
  logic                  r_ready;
  logic [1:0]            r_resp;
  logic [DATA_WIDTH-1:0] r_data;

  modport master (
    output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
    input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_resp, r_data
  );

  modport slave (
    input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
    output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_resp, r_data
  );

endinterface

// File: design/axi_sram_slave.sv
`timescale 1ns/1ps

module axi_sram_slave #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 64,
  parameter int MEM_WORDS  = 1024
) (
  input logic       clk,
  input logic       rst,
  axi_lite_if.slave bus
);

  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int IDX_WIDTH       = $clog2(MEM_WORDS);
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - mem_pkg::WORD_OFFSET_BITS;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  rd_state_t rd_state;
  wr_state_t wr_state;

  logic ar_fire;
  logic r_fire;
  logic aw_fire;
  logic w_fire;
  logic b_fire;

  logic [WORD_ADDR_WIDTH-1:0] ar_word;
  logic [WORD_ADDR_WIDTH-1:0] aw_word;
  logic                       ar_in_range;
  logic                       aw_in_range;

  // captured write transaction
  logic [IDX_WIDTH-1:0]  wr_idx;
  logic                  wr_in_range;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [STRB_WIDTH-1:0] wr_strb;

  assign ar_fire = bus.ar_valid && bus.ar_ready;
  assign r_fire  = bus.r_valid && bus.r_ready;
  assign aw_fire = bus.aw_valid && bus.aw_ready;
  assign w_fire  = bus.w_valid && bus.w_ready;
  assign b_fire  = bus.b_valid && bus.b_ready;

  // low address bits dropped, words only
  assign ar_word     = bus.ar_addr[ADDR_WIDTH-1:mem_pkg::WORD_OFFSET_BITS];
  assign aw_word     = bus.aw_addr[ADDR_WIDTH-1:mem_pkg::WORD_OFFSET_BITS];
  assign ar_in_range = ar_word < MEM_WORDS;
  assign aw_in_range = aw_word < MEM_WORDS;

  // read fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state     <= RD_IDLE;
      bus.ar_ready <= 1'b1;
      bus.r_valid  <= 1'b0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (ar_fire) begin
            rd_state     <= RD_RESP;
            bus.ar_ready <= 1'b0;
            bus.r_valid  <= 1'b1;
          end
        end
        RD_RESP: begin
          // hold response until master takes it
          if (r_fire) begin
            rd_state     <= RD_IDLE;
            bus.ar_ready <= 1'b1;
            bus.r_valid  <= 1'b0;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // word latched on address acceptance
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      bus.r_data <= ar_in_range ? mem[ar_word[IDX_WIDTH-1:0]] : '0;
      bus.r_resp <= ar_in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
    end
  end

  // write fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state     <= WR_IDLE;
      bus.aw_ready <= 1'b1;
      bus.w_ready  <= 1'b0;
      bus.b_valid  <= 1'b0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (aw_fire) begin
            wr_state     <= WR_DATA;
            bus.aw_ready <= 1'b0;
            bus.w_ready  <= 1'b1;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            wr_state    <= WR_RESP;
            bus.w_ready <= 1'b0;
            bus.b_valid <= 1'b1;
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            wr_state     <= WR_IDLE;
            bus.aw_ready <= 1'b1;
            bus.b_valid  <= 1'b0;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_idx      <= aw_word[IDX_WIDTH-1:0];
      wr_in_range <= aw_in_range;
    end
    if (w_fire) begin
      wr_data    <= bus.w_data;
      wr_strb    <= bus.w_strb;
      bus.b_resp <= wr_in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
    end
  end

  // byte-masked write at response handshake, dropped when out of range
  always_ff @(posedge clk) begin
    if (b_fire && wr_in_range) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wr_strb[i]) begin
          mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

endmodule

// File: design/axi_read_arbiter.sv
`timescale 1ns/1ps

module axi_read_arbiter #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 64
) (
  input  logic                    clk,
  input  logic                    rst,
  axi_lite_if.slave               ifu,
  input  logic                    lsu_aw_valid_i,
  input  logic [ADDR_WIDTH-1:0]   lsu_aw_addr_i,
  output logic                    lsu_aw_ready_o,
  input  logic                    lsu_w_valid_i,
  input  logic [DATA_WIDTH-1:0]   lsu_w_data_i,
  input  logic [DATA_WIDTH/8-1:0] lsu_w_strb_i,
  output logic                    lsu_w_ready_o,
  input  logic                    lsu_b_ready_i,
  output logic                    lsu_b_valid_o,
  output logic [1:0]              lsu_b_resp_o,
  input  logic                    lsu_ar_valid_i,
  input  logic [ADDR_WIDTH-1:0]   lsu_ar_addr_i,
  output logic                    lsu_ar_ready_o,
  input  logic                    lsu_r_ready_i,
  output logic                    lsu_r_valid_o,
  output logic [1:0]              lsu_r_resp_o,
  output logic [DATA_WIDTH-1:0]   lsu_r_data_o,
  axi_lite_if.master              mem
);

  // one-hot read owner with fetch in bit 0
  logic [1:0] grant;
  logic       locked;
  logic       last_lsu;
  logic       pick_lsu;

  assign locked = |grant;

  // tie goes to the master that lost the last tie
  assign pick_lsu = lsu_ar_valid_i && (!ifu.ar_valid || !last_lsu);

  // ar mux while unlocked
  assign mem.ar_valid   = !locked && (ifu.ar_valid || lsu_ar_valid_i);
  assign mem.ar_addr    = pick_lsu ? lsu_ar_addr_i : ifu.ar_addr;
  assign ifu.ar_ready   = !locked && !pick_lsu && mem.ar_ready;
  assign lsu_ar_ready_o = !locked && pick_lsu && mem.ar_ready;

  // r back to the owner
  assign ifu.r_valid   = grant[0] && mem.r_valid;
  assign lsu_r_valid_o = grant[1] && mem.r_valid;
  assign mem.r_ready   = (grant[0] && ifu.r_ready) || (grant[1] && lsu_r_ready_i);
  assign ifu.r_data    = mem.r_data;
  assign ifu.r_resp    = mem.r_resp;
  assign lsu_r_data_o  = mem.r_data;
  assign lsu_r_resp_o  = mem.r_resp;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant    <= 2'b00;
      last_lsu <= 1'b1;
    end else if (mem.ar_valid && mem.ar_ready) begin
      grant <= pick_lsu ? 2'b10 : 2'b01;
      // pointer moves only when both request
      if (ifu.ar_valid && lsu_ar_valid_i) begin
        last_lsu <= pick_lsu;
      end
    end else if (mem.r_valid && mem.r_ready) begin
      grant <= 2'b00;
    end
  end

  // writes come from load/store only
  assign mem.aw_valid   = lsu_aw_valid_i;
  assign mem.aw_addr    = lsu_aw_addr_i;
  assign lsu_aw_ready_o = mem.aw_ready;
  assign mem.w_valid    = lsu_w_valid_i;
  assign mem.w_data     = lsu_w_data_i;
  assign mem.w_strb     = lsu_w_strb_i;
  assign lsu_w_ready_o  = mem.w_ready;
  assign mem.b_ready    = lsu_b_ready_i;
  assign lsu_b_valid_o  = mem.b_valid;
  assign lsu_b_resp_o   = mem.b_resp;

  // fetch never writes
  assign ifu.aw_ready = 1'b0;
  assign ifu.w_ready  = 1'b0;
  assign ifu.b_valid  = 1'b0;
  assign ifu.b_resp   = axi_pkg::RESP_OKAY;

endmodule

// File: design/axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top #(
  parameter int ADDR_WIDTH = axi_pkg::ADDR_W_DEFAULT,
  parameter int DATA_WIDTH = axi_pkg::DATA_W_DEFAULT,
  parameter int MEM_WORDS  = mem_pkg::MEM_WORDS_DEFAULT
) (
  input  logic                    clk,
  input  logic                    rst,
  // fetch, read only
  input  logic                    ifu_ar_valid_i,
  input  logic [ADDR_WIDTH-1:0]   ifu_ar_addr_i,
  output logic                    ifu_ar_ready_o,
  input  logic                    ifu_r_ready_i,
  output logic                    ifu_r_valid_o,
  output logic [1:0]              ifu_r_resp_o,
  output logic [DATA_WIDTH-1:0]   ifu_r_data_o,
  // load/store
  input  logic                    lsu_aw_valid_i,
  input  logic [ADDR_WIDTH-1:0]   lsu_aw_addr_i,
  output logic                    lsu_aw_ready_o,
  input  logic                    lsu_w_valid_i,
  input  logic [DATA_WIDTH-1:0]   lsu_w_data_i,
  input  logic [DATA_WIDTH/8-1:0] lsu_w_strb_i,
  output logic                    lsu_w_ready_o,
  input  logic                    lsu_b_ready_i,
  output logic                    lsu_b_valid_o,
  output logic [1:0]              lsu_b_resp_o,
  input  logic                    lsu_ar_valid_i,
  input  logic [ADDR_WIDTH-1:0]   lsu_ar_addr_i,
  output logic                    lsu_ar_ready_o,
  input  logic                    lsu_r_ready_i,
  output logic                    lsu_r_valid_o,
  output logic [1:0]              lsu_r_resp_o,
  output logic [DATA_WIDTH-1:0]   lsu_r_data_o
);

  axi_lite_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) ifu_bus ();
  axi_lite_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) mem_bus ();

  assign ifu_bus.ar_valid = ifu_ar_valid_i;
  assign ifu_bus.ar_addr  = ifu_ar_addr_i;
  assign ifu_ar_ready_o   = ifu_bus.ar_ready;
  assign ifu_bus.r_ready  = ifu_r_ready_i;
  assign ifu_r_valid_o    = ifu_bus.r_valid;
  assign ifu_r_resp_o     = ifu_bus.r_resp;
  assign ifu_r_data_o     = ifu_bus.r_data;

  // fetch write channels held idle
  assign ifu_bus.aw_valid = 1'b0;
  assign ifu_bus.aw_addr  = '0;
  assign ifu_bus.w_valid  = 1'b0;
  assign ifu_bus.w_data   = '0;
  assign ifu_bus.w_strb   = '0;
  assign ifu_bus.b_ready  = 1'b0;

  axi_read_arbiter #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu            (ifu_bus.slave),
    .lsu_aw_valid_i (lsu_aw_valid_i),
    .lsu_aw_addr_i  (lsu_aw_addr_i),
    .lsu_aw_ready_o (lsu_aw_ready_o),
    .lsu_w_valid_i  (lsu_w_valid_i),
    .lsu_w_data_i   (lsu_w_data_i),
    .lsu_w_strb_i   (lsu_w_strb_i),
    .lsu_w_ready_o  (lsu_w_ready_o),
    .lsu_b_ready_i  (lsu_b_ready_i),
    .lsu_b_valid_o  (lsu_b_valid_o),
    .lsu_b_resp_o   (lsu_b_resp_o),
    .lsu_ar_valid_i (lsu_ar_valid_i),
    .lsu_ar_addr_i  (lsu_ar_addr_i),
    .lsu_ar_ready_o (lsu_ar_ready_o),
    .lsu_r_ready_i  (lsu_r_ready_i),
    .lsu_r_valid_o  (lsu_r_valid_o),
    .lsu_r_resp_o   (lsu_r_resp_o),
    .lsu_r_data_o   (lsu_r_data_o),
    .mem            (mem_bus.master)
  );

  axi_sram_slave #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clk (clk),
    .rst (rst),
    .bus (mem_bus.slave)
  );

endmodule

// File: include/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// handshake signals a wait can watch
localparam int SEL_AW  = 0;
localparam int SEL_W   = 1;
localparam int SEL_B   = 2;
localparam int SEL_LAR = 3;
localparam int SEL_LR  = 4;
localparam int SEL_IAR = 5;
localparam int SEL_IR  = 6;

localparam int          TIMEOUT_CYCLES = 100;
localparam logic [31:0] LOW_MASK       = (32'd1 << mem_pkg::WORD_OFFSET_BITS) - 1;

function automatic logic [31:0] next_rand();
  rng_state = rng_state * 32'd1103515245 + 32'd12345;
  return rng_state;
endfunction

function automatic logic [ADDR_W-1:0] rand_addr();
  logic [31:0] word;
  word = (next_rand() >> 8) % MEM_WORDS;
  return ADDR_W'((word << mem_pkg::WORD_OFFSET_BITS) | ((next_rand() >> 16) & LOW_MASK));
endfunction

function automatic logic [DATA_W-1:0] rand_data();
  return {next_rand(), next_rand()};
endfunction

function automatic logic probe(input int sel);
  case (sel)
    SEL_AW:  return lsu_aw_ready_o;
    SEL_W:   return lsu_w_ready_o;
    SEL_B:   return lsu_b_valid_o;
    SEL_LAR: return lsu_ar_ready_o;
    SEL_LR:  return lsu_r_valid_o;
    SEL_IAR: return ifu_ar_ready_o;
    SEL_IR:  return ifu_r_valid_o;
    default: return 1'b0;
  endcase
endfunction

// returns just after a falling edge with the signal high
task automatic wait_for(input int sel, input string what);
  int n;
  n = 0;
  #1;
  while (!probe(sel)) begin
    if (n == TIMEOUT_CYCLES) begin
      fail_now($sformatf("timeout waiting for %s", what));
    end
    @(negedge clk);
    #1;
    n++;
  end
endtask

// expected read result from the reference memory
task automatic expect_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic [1:0] resp);
  int idx;
  idx = int'(addr >> mem_pkg::WORD_OFFSET_BITS);
  if (idx < MEM_WORDS) begin
    data = ref_mem[idx];
    resp = axi_pkg::RESP_OKAY;
  end else begin
    data = '0;
    resp = axi_pkg::RESP_SLVERR;
  end
endtask

task automatic check_read(input string name, input logic [DATA_W-1:0] exp_data,
                          input logic [1:0] exp_resp, input logic [DATA_W-1:0] data,
                          input logic [1:0] resp);
  assert (resp === exp_resp) else report_mismatch({name, " resp"}, exp_resp, resp);
  assert (data === exp_data) else report_mismatch({name, " data"}, exp_data, data);
endtask

task automatic write_lsu(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                         input logic [STRB_W-1:0] strb, input int hold, input string name);
  int                idx;
  logic [1:0]        exp_resp;
  logic [DATA_W-1:0] word;
  idx      = int'(addr >> mem_pkg::WORD_OFFSET_BITS);
  exp_resp = (idx < MEM_WORDS) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
  @(negedge clk);
  lsu_aw_valid = 1'b1;
  lsu_aw_addr  = addr;
  lsu_b_ready  = 1'b0;
  wait_for(SEL_AW, "lsu aw_ready");
  @(negedge clk);
  lsu_aw_valid = 1'b0;
  lsu_w_valid  = 1'b1;
  lsu_w_data   = data;
  lsu_w_strb   = strb;
  wait_for(SEL_W, "lsu w_ready");
  @(negedge clk);
  lsu_w_valid = 1'b0;
  wait_for(SEL_B, "lsu b_valid");
  assert (lsu_b_resp_o === exp_resp) else report_mismatch({name, " bresp"}, exp_resp,
                                                          lsu_b_resp_o);
  repeat (hold) @(negedge clk);
  @(negedge clk);
  lsu_b_ready = 1'b1;
  @(negedge clk);
  lsu_b_ready = 1'b0;
  // bytes never written stay unknown
  if (exp_resp == axi_pkg::RESP_OKAY) begin
    word = ref_mem.exists(idx) ? ref_mem[idx] : {DATA_W{1'bx}};
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        word[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    ref_mem[idx] = word;
  end
endtask

task automatic read_lsu(input logic [ADDR_W-1:0] addr, input int hold, input string name);
  logic [DATA_W-1:0] exp_data;
  logic [1:0]        exp_resp;
  expect_read(addr, exp_data, exp_resp);
  @(negedge clk);
  lsu_ar_valid = 1'b1;
  lsu_ar_addr  = addr;
  lsu_r_ready  = 1'b0;
  wait_for(SEL_LAR, "lsu ar_ready");
  lsu_ar_time = $realtime;
  @(negedge clk);
  lsu_ar_valid = 1'b0;
  wait_for(SEL_LR, "lsu r_valid");
  check_read(name, exp_data, exp_resp, lsu_r_data_o, lsu_r_resp_o);
  repeat (hold) @(negedge clk);
  @(negedge clk);
  lsu_r_ready = 1'b1;
  @(negedge clk);
  lsu_r_ready = 1'b0;
endtask

task automatic read_ifu(input logic [ADDR_W-1:0] addr, input int hold, input string name);
  logic [DATA_W-1:0] exp_data;
  logic [1:0]        exp_resp;
  expect_read(addr, exp_data, exp_resp);
  @(negedge clk);
  ifu_ar_valid = 1'b1;
  ifu_ar_addr  = addr;
  ifu_r_ready  = 1'b0;
  wait_for(SEL_IAR, "ifu ar_ready");
  ifu_ar_time = $realtime;
  @(negedge clk);
  ifu_ar_valid = 1'b0;
  wait_for(SEL_IR, "ifu r_valid");
  check_read(name, exp_data, exp_resp, ifu_r_data_o, ifu_r_resp_o);
  repeat (hold) @(negedge clk);
  @(negedge clk);
  ifu_r_ready = 1'b1;
  @(negedge clk);
  ifu_r_ready = 1'b0;
endtask

`endif

// File: bench/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem;

  localparam int ADDR_W    = axi_pkg::ADDR_W_DEFAULT;
  localparam int DATA_W    = axi_pkg::DATA_W_DEFAULT;
  localparam int STRB_W    = DATA_W / 8;
  localparam int MEM_WORDS = mem_pkg::MEM_WORDS_DEFAULT;

  logic clk = 1'b0;
  logic rst;

  logic              ifu_ar_valid;
  logic [ADDR_W-1:0] ifu_ar_addr;
  logic              ifu_ar_ready_o;
  logic              ifu_r_ready;
  logic              ifu_r_valid_o;
  logic [1:0]        ifu_r_resp_o;
  logic [DATA_W-1:0] ifu_r_data_o;

  logic              lsu_aw_valid;
  logic [ADDR_W-1:0] lsu_aw_addr;
  logic              lsu_aw_ready_o;
  logic              lsu_w_valid;
  logic [DATA_W-1:0] lsu_w_data;
  logic [STRB_W-1:0] lsu_w_strb;
  logic              lsu_w_ready_o;
  logic              lsu_b_ready;
  logic              lsu_b_valid_o;
  logic [1:0]        lsu_b_resp_o;
  logic              lsu_ar_valid;
  logic [ADDR_W-1:0] lsu_ar_addr;
  logic              lsu_ar_ready_o;
  logic              lsu_r_ready;
  logic              lsu_r_valid_o;
  logic [1:0]        lsu_r_resp_o;
  logic [DATA_W-1:0] lsu_r_data_o;

  // reference memory by word index
  logic [DATA_W-1:0] ref_mem [int];
  logic [31:0]       rng_state = 32'd47455;
  realtime           ifu_ar_time;
  realtime           lsu_ar_time;
  logic [ADDR_W-1:0] addrs [8];
  logic [ADDR_W-1:0] addr;
  int                hold;
  logic              exp_ifu_first;

  always #5 clk = ~clk;

  axi_mem_top u_dut (
    .clk            (clk),
    .rst            (rst),
    .ifu_ar_valid_i (ifu_ar_valid),
    .ifu_ar_addr_i  (ifu_ar_addr),
    .ifu_ar_ready_o (ifu_ar_ready_o),
    .ifu_r_ready_i  (ifu_r_ready),
    .ifu_r_valid_o  (ifu_r_valid_o),
    .ifu_r_resp_o   (ifu_r_resp_o),
    .ifu_r_data_o   (ifu_r_data_o),
    .lsu_aw_valid_i (lsu_aw_valid),
    .lsu_aw_addr_i  (lsu_aw_addr),
    .lsu_aw_ready_o (lsu_aw_ready_o),
    .lsu_w_valid_i  (lsu_w_valid),
    .lsu_w_data_i   (lsu_w_data),
    .lsu_w_strb_i   (lsu_w_strb),
    .lsu_w_ready_o  (lsu_w_ready_o),
    .lsu_b_ready_i  (lsu_b_ready),
    .lsu_b_valid_o  (lsu_b_valid_o),
    .lsu_b_resp_o   (lsu_b_resp_o),
    .lsu_ar_valid_i (lsu_ar_valid),
    .lsu_ar_addr_i  (lsu_ar_addr),
    .lsu_ar_ready_o (lsu_ar_ready_o),
    .lsu_r_ready_i  (lsu_r_ready),
    .lsu_r_valid_o  (lsu_r_valid_o),
    .lsu_r_resp_o   (lsu_r_resp_o),
    .lsu_r_data_o   (lsu_r_data_o)
  );

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input logic [DATA_W-1:0] exp,
                                 input logic [DATA_W-1:0] act);
    fail_now($sformatf("MISMATCH %s expected=%0h actual=%0h", test, exp, act));
  endtask

  `include "tb_axi_tasks.svh"

  // r_valid exactly one cycle after the ar transfer
  ifu_latency: assert property (@(posedge clk) disable iff (rst)
    ifu_ar_valid && ifu_ar_ready_o |=> ifu_r_valid_o)
    else fail_now("ifu r_valid did not rise one cycle after the ar transfer");
  lsu_latency: assert property (@(posedge clk) disable iff (rst)
    lsu_ar_valid && lsu_ar_ready_o |=> lsu_r_valid_o)
    else fail_now("lsu r_valid did not rise one cycle after the ar transfer");

  // held responses stay put
  ifu_r_hold: assert property (@(posedge clk) disable iff (rst)
    ifu_r_valid_o && !ifu_r_ready |=> ifu_r_valid_o && $stable(ifu_r_data_o)
      && $stable(ifu_r_resp_o))
    else fail_now("ifu read response changed while r_ready was low");
  lsu_r_hold: assert property (@(posedge clk) disable iff (rst)
    lsu_r_valid_o && !lsu_r_ready |=> lsu_r_valid_o && $stable(lsu_r_data_o)
      && $stable(lsu_r_resp_o))
    else fail_now("lsu read response changed while r_ready was low");
  lsu_b_hold: assert property (@(posedge clk) disable iff (rst)
    lsu_b_valid_o && !lsu_b_ready |=> lsu_b_valid_o && $stable(lsu_b_resp_o))
    else fail_now("write response changed while b_ready was low");

  // one read in flight at a time
  single_read: assert property (@(posedge clk) disable iff (rst)
    (ifu_r_valid_o || lsu_r_valid_o) |-> !(ifu_ar_ready_o || lsu_ar_ready_o))
    else fail_now("a second read address was accepted while a response was pending");

  initial begin
    rst          = 1'b1;
    ifu_ar_valid = 1'b0;
    ifu_ar_addr  = '0;
    ifu_r_ready  = 1'b0;
    lsu_aw_valid = 1'b0;
    lsu_aw_addr  = '0;
    lsu_w_valid  = 1'b0;
    lsu_w_data   = '0;
    lsu_w_strb   = '0;
    lsu_b_ready  = 1'b0;
    lsu_ar_valid = 1'b0;
    lsu_ar_addr  = '0;
    lsu_r_ready  = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    #1;
    assert (ifu_ar_ready_o && lsu_aw_ready_o)
      else fail_now("ready outputs not high after reset");
    assert (!ifu_r_valid_o && !lsu_r_valid_o && !lsu_b_valid_o && !lsu_w_ready_o)
      else fail_now("valid outputs not low after reset");

    // full words read back with other low address bits
    for (int i = 0; i < 8; i++) begin
      addrs[i] = rand_addr();
      write_lsu(addrs[i], rand_data(), '1, 0, $sformatf("write %0d", i));
    end
    for (int i = 0; i < 8; i++) begin
      addr = addrs[i] ^ ADDR_W'((next_rand() >> 16) & LOW_MASK);
      read_lsu(addr, 0, $sformatf("readback %0d", i));
    end

    write_lsu(addrs[0], rand_data(), 8'b0110_1001, 0, "strobe fixed");
    read_ifu(addrs[0], 0, "strobe fixed merge");
    write_lsu(addrs[0], rand_data(), STRB_W'(next_rand() >> 12), 0, "strobe random");
    read_ifu(addrs[0], 0, "strobe random merge");

    // both masters at once so the order swaps between rounds
    for (int round = 0; round < 2; round++) begin
      fork
        read_ifu(addrs[2], 0, $sformatf("arb ifu %0d", round));
        read_lsu(addrs[3], 0, $sformatf("arb lsu %0d", round));
      join
      if (round > 0) begin
        assert ((ifu_ar_time < lsu_ar_time) == exp_ifu_first)
          else report_mismatch($sformatf("arb order %0d", round), exp_ifu_first,
                               ifu_ar_time < lsu_ar_time);
      end
      // served second in this round
      exp_ifu_first = lsu_ar_time < ifu_ar_time;
    end

    read_lsu(ADDR_W'(MEM_WORDS + 5) << mem_pkg::WORD_OFFSET_BITS, 0, "oob read");
    addr = addrs[1] + (ADDR_W'(MEM_WORDS) << mem_pkg::WORD_OFFSET_BITS);
    write_lsu(addr, rand_data(), '1, 0, "oob write");
    read_ifu(addrs[1], 0, "oob alias");

    // held responses with the other master queued behind
    for (int i = 0; i < 4; i++) begin
      hold = 1 + int'((next_rand() >> 8) % 5);
      write_lsu(addrs[4+i], rand_data(), '1, hold, $sformatf("bp write %0d", i));
      fork
        read_lsu(addrs[4+i], hold, $sformatf("bp lsu %0d", i));
        read_ifu(addrs[i], 0, $sformatf("bp ifu %0d", i));
      join
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// File: all.f
+incdir+include
design/axi_pkg.sv
design/mem_pkg.sv
design/axi_lite_if.sv
design/axi_sram_slave.sv
design/axi_read_arbiter.sv
design/axi_mem_top.sv
bench/tb_axi_mem.sv
